// File: Makefile
TOP = periph_bus_tb

all: run

compile:
	verilator --binary --top-module $(TOP) -f periph_bus_top.f -o V$(TOP)

# Passes only when the pass message shows up in the simulation output
run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

.PHONY: all compile run clean

// File: periph_bus_top.f
+incdir+rtl
rtl/periph_pkg.sv
rtl/periph_decode.sv
rtl/gpio_ctrl.sv
rtl/word_scratch_peri.sv
rtl/byte_scratch_peri.sv
rtl/read_return.sv
rtl/periph_bus_top.sv
sim/periph_bus_tb.sv

// File: rtl/byte_scratch_peri.sv
/*
 * Byte scratch peripheral
 * Four byte registers on the byte interface, register 0 on the pins
 */
`timescale 1ns/1ns

module byte_scratch_peri (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [3:0]        i_addr_ofs,
    input  logic              i_write,
    input  periph_pkg::byte_t i_data,
    output periph_pkg::byte_t o_rdata,
    output periph_pkg::byte_t o_uo_out
);
    import periph_pkg::*;

    byte_t regs [4];
    logic  hit;

    assign hit = i_addr_ofs[3:2] == 2'b00;  // Offsets 0-3

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < 4; r++) begin
                regs[r] <= '0;
            end
        end else if (i_write && hit) begin
            regs[i_addr_ofs[1:0]] <= i_data;
        end
    end

    assign o_rdata  = hit ? regs[i_addr_ofs[1:0]] : '0;
    assign o_uo_out = regs[0];

endmodule

// File: rtl/gpio_ctrl.sv
/*
 * GPIO block
 * Output register, input pin readback and eight per-pin function
 * selects that route each output pin from any slot
 */
`timescale 1ns/1ns
`include "periph_settings.svh"

module gpio_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [5:0]             i_addr_ofs,
    input  periph_pkg::word_t      i_data,
    input  periph_pkg::xfer_size_t i_write_n,
    input  periph_pkg::xfer_size_t i_read_n,
    input  periph_pkg::byte_t      i_ui_in,
    input  periph_pkg::byte_t      i_word_pins [`PERI_NUM_SLOTS],
    input  periph_pkg::byte_t      i_byte_pins [`PERI_NUM_SLOTS],
    output periph_pkg::word_t      o_rdata,
    output logic                   o_ready,
    output periph_pkg::byte_t      o_uo_out
);
    import periph_pkg::*;

    byte_t      gpio_out;
    func_sel_t  func_sel [8];
    logic       wr_en;
    logic       func_hit;
    logic [2:0] func_idx;
    byte_t      word_src [`PERI_NUM_SLOTS];

    assign wr_en    = i_write_n != XFER_NONE;
    assign func_idx = i_addr_ofs[4:2];

    // Any word offset from 0x20 up to 0x3C
    assign func_hit = {i_addr_ofs[5], 3'b000, i_addr_ofs[1:0]} == `GPIO_OFS_FUNC_BASE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            for (int p = 0; p < 8; p++) begin
                func_sel[p] <= (p < 2) ? `GPIO_FUNC_RESET_LOW : `GPIO_FUNC_RESET_HIGH;
            end
        end else if (wr_en) begin
            if (i_addr_ofs == `GPIO_OFS_OUT) begin
                gpio_out <= i_data[7:0];
            end
            if (func_hit) begin
                func_sel[func_idx] <= i_data[4:0];
            end
        end
    end

    always_comb begin
        o_rdata = '0;                           // Unused offsets read zero
        if (i_addr_ofs == `GPIO_OFS_OUT) begin
            o_rdata = {24'h0, gpio_out};
        end else if (i_addr_ofs == `GPIO_OFS_IN) begin
            o_rdata = {24'h0, i_ui_in};
        end else if (func_hit) begin
            o_rdata = {27'h0, func_sel[func_idx]};
        end
    end

    assign o_ready = i_read_n != XFER_NONE;    // Registers answer as soon as asked

    // The GPIO slot entry carries this block's own output register
    always_comb begin
        for (int s = 0; s < `PERI_NUM_SLOTS; s++) begin
            word_src[s] = i_word_pins[s];
        end
        word_src[`PERI_SLOT_GPIO] = gpio_out;
    end

    // Each pin takes its own bit from the slot its select names
    always_comb begin
        for (int p = 0; p < 8; p++) begin
            if (func_sel[p][4]) begin
                o_uo_out[p] = i_byte_pins[func_sel[p][3:0]][p];
            end else begin
                o_uo_out[p] = word_src[func_sel[p][3:0]][p];
            end
        end
    end

endmodule

// File: rtl/periph_bus_top.sv
/*
 * Peripheral bus core
 * Address decode, GPIO, two scratch peripherals and the read return
 * path, with the empty slots tied off
 */
`timescale 1ns/1ns
`include "periph_settings.svh"

module periph_bus_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  periph_pkg::byte_t      i_ui_in,
    input  periph_pkg::addr_t      i_addr,
    input  periph_pkg::word_t      i_data,
    input  periph_pkg::xfer_size_t i_write_n,
    input  periph_pkg::xfer_size_t i_read_n,
    input  logic                   i_read_complete,
    output periph_pkg::word_t      o_data,
    output logic                   o_ready,
    output periph_pkg::byte_t      o_uo_out
);
    import periph_pkg::*;

    wire word_t      word_rdata [`PERI_NUM_SLOTS];
    wire slot_sel_t  word_ready;
    wire byte_t      byte_rdata [`PERI_NUM_SLOTS];
    wire xfer_size_t word_write_n [`PERI_NUM_SLOTS];
    wire xfer_size_t word_read_n [`PERI_NUM_SLOTS];
    wire slot_sel_t  byte_write;
    wire byte_t      word_pins [`PERI_NUM_SLOTS];
    wire byte_t      byte_pins [`PERI_NUM_SLOTS];
    wire xfer_size_t read_n_masked;
    wire word_t      rdata;
    wire             rready;

    // Empty word slots read zero and are ready at once
    for (genvar s = 0; s < `PERI_NUM_SLOTS; s++) begin : g_word_tie
        if (s != `PERI_SLOT_GPIO && s != `PERI_SLOT_SCRATCH) begin : g_empty
            assign word_rdata[s] = '0;
            assign word_ready[s] = 1'b1;
        end
        if (s != `PERI_SLOT_SCRATCH) begin : g_no_pins
            assign word_pins[s] = '0;   // GPIO routes its own register internally
        end
    end

    for (genvar s = 0; s < `PERI_NUM_SLOTS; s++) begin : g_byte_tie
        if (s != `PERI_SLOT_BYTES) begin : g_empty
            assign byte_rdata[s] = '0;
            assign byte_pins[s]  = '0;
        end
    end

    periph_decode u_decode (
        .i_addr          (i_addr),
        .i_write_n       (i_write_n),
        .i_read_n_masked (read_n_masked),
        .i_word_rdata    (word_rdata),
        .i_word_ready    (word_ready),
        .i_byte_rdata    (byte_rdata),
        .o_word_write_n  (word_write_n),
        .o_word_read_n   (word_read_n),
        .o_byte_write    (byte_write),
        .o_rdata         (rdata),
        .o_rready        (rready)
    );

    gpio_ctrl u_gpio (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_addr_ofs  (i_addr[5:0]),
        .i_data      (i_data),
        .i_write_n   (word_write_n[`PERI_SLOT_GPIO]),
        .i_read_n    (word_read_n[`PERI_SLOT_GPIO]),
        .i_ui_in     (i_ui_in),
        .i_word_pins (word_pins),
        .i_byte_pins (byte_pins),
        .o_rdata     (word_rdata[`PERI_SLOT_GPIO]),
        .o_ready     (word_ready[`PERI_SLOT_GPIO]),
        .o_uo_out    (o_uo_out)
    );

    word_scratch_peri u_word_scratch (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_addr_ofs (i_addr[5:0]),
        .i_data     (i_data),
        .i_write_n  (word_write_n[`PERI_SLOT_SCRATCH]),
        .i_read_n   (word_read_n[`PERI_SLOT_SCRATCH]),
        .o_rdata    (word_rdata[`PERI_SLOT_SCRATCH]),
        .o_ready    (word_ready[`PERI_SLOT_SCRATCH]),
        .o_uo_out   (word_pins[`PERI_SLOT_SCRATCH])
    );

    byte_scratch_peri u_byte_scratch (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_addr_ofs (i_addr[3:0]),
        .i_write    (byte_write[`PERI_SLOT_BYTES]),
        .i_data     (i_data[7:0]),
        .o_rdata    (byte_rdata[`PERI_SLOT_BYTES]),
        .o_uo_out   (byte_pins[`PERI_SLOT_BYTES])
    );

    read_return u_read_return (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_read_n),
        .i_write_n       (i_write_n),
        .i_read_complete (i_read_complete),
        .i_rdata         (rdata),
        .i_rready        (rready),
        .o_read_n_masked (read_n_masked),
        .o_data          (o_data),
        .o_ready         (o_ready)
    );

endmodule

// File: rtl/periph_decode.sv
/*
 * Peripheral address decode
 * Turns the bus address into per-slot size codes and write strobes,
 * and picks the read data and ready of the addressed slot
 */
`timescale 1ns/1ns
`include "periph_settings.svh"

module periph_decode (
    input  periph_pkg::addr_t      i_addr,
    input  periph_pkg::xfer_size_t i_write_n,
    input  periph_pkg::xfer_size_t i_read_n_masked,
    input  periph_pkg::word_t      i_word_rdata [`PERI_NUM_SLOTS],
    input  periph_pkg::slot_sel_t  i_word_ready,
    input  periph_pkg::byte_t      i_byte_rdata [`PERI_NUM_SLOTS],
    output periph_pkg::xfer_size_t o_word_write_n [`PERI_NUM_SLOTS],
    output periph_pkg::xfer_size_t o_word_read_n [`PERI_NUM_SLOTS],
    output periph_pkg::slot_sel_t  o_byte_write,
    output periph_pkg::word_t      o_rdata,
    output logic                   o_rready
);
    import periph_pkg::*;

    logic      byte_space;
    slot_idx_t word_idx;
    slot_idx_t byte_idx;
    slot_sel_t word_sel;
    slot_sel_t byte_sel;

    assign byte_space = i_addr[10];
    assign word_idx   = i_addr[9:6];    // 64-byte windows
    assign byte_idx   = i_addr[7:4];    // 16-byte windows

    always_comb begin
        word_sel = '0;
        byte_sel = '0;
        if (byte_space) begin
            byte_sel[byte_idx] = 1'b1;
        end else begin
            word_sel[word_idx] = 1'b1;
        end
    end

    // Unselected word slots see no transfer
    always_comb begin
        for (int s = 0; s < `PERI_NUM_SLOTS; s++) begin
            o_word_write_n[s] = word_sel[s] ? i_write_n : XFER_NONE;
            o_word_read_n[s]  = word_sel[s] ? i_read_n_masked : XFER_NONE;
        end
    end

    assign o_byte_write = byte_sel & {`PERI_NUM_SLOTS{i_write_n != XFER_NONE}};

    always_comb begin
        if (byte_space) begin
            o_rdata  = {24'h0, i_byte_rdata[byte_idx]};
            o_rready = 1'b1;                    // Byte slots answer at once
        end else begin
            o_rdata  = i_word_rdata[word_idx];
            o_rready = i_word_ready[word_idx];
        end
    end

endmodule

// File: rtl/periph_pkg.sv
/*
 * Peripheral bus types
 * Address, data, size codes and slot selects shared by the wrapper
 */
package periph_pkg;

    typedef logic [10:0] addr_t;    // Peripheral address from the core
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;    // Pin group or byte data

    // Active-low transfer size, as driven by the core
    typedef enum logic [1:0] {
        XFER_BYTE = 2'b00,
        XFER_HALF = 2'b01,
        XFER_WORD = 2'b10,
        XFER_NONE = 2'b11
    } xfer_size_t;

    typedef logic [15:0] slot_sel_t;  // One-hot slot select
    typedef logic [3:0]  slot_idx_t;

    // Bit 4 picks the byte slots, bits 3:0 the slot index
    typedef logic [4:0]  func_sel_t;

endpackage

// File: rtl/periph_settings.svh
/*
 * Peripheral bus settings
 * Slot map, GPIO register offsets and reset routing of the output pins
 */
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// Slot map, per interface kind
`define PERI_NUM_SLOTS      16
`define PERI_SLOT_GPIO      1
`define PERI_SLOT_SCRATCH   2
`define PERI_SLOT_BYTES     0

// GPIO register offsets within its 64-byte window
`define GPIO_OFS_OUT        6'h00
`define GPIO_OFS_IN         6'h04
`define GPIO_OFS_FUNC_BASE  6'h20   // Eight selects, 0x20 to 0x3C

`define GPIO_FUNC_RESET_LOW   5'd2  // Pins 0-1, word scratch slot
`define GPIO_FUNC_RESET_HIGH  5'd1  // Pins 2-7, GPIO slot

`endif

// File: rtl/read_return.sv
/*
 * Read return path
 * Captures slot read data once, holds it until the core reports the
 * read complete, and masks further reads while the result is pending
 */
`timescale 1ns/1ns

module read_return (
    input  logic                   clk,
    input  logic                   rst_n,
    input  periph_pkg::xfer_size_t i_read_n,
    input  periph_pkg::xfer_size_t i_write_n,
    input  logic                   i_read_complete,
    input  periph_pkg::word_t      i_rdata,
    input  logic                   i_rready,
    output periph_pkg::xfer_size_t o_read_n_masked,
    output periph_pkg::word_t      o_data,
    output logic                   o_ready
);
    import periph_pkg::*;

    word_t data_r;
    logic  hold;
    logic  ready_r;
    logic  read_req;
    logic  capture;

    assign read_req = i_read_n != XFER_NONE;
    assign capture  = !hold && read_req && i_rready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold <= 1'b0;
            end
            if (capture) begin
                hold <= 1'b1;
            end
            ready_r <= read_req && i_rready;    // Follows the registered data
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_r <= i_rdata;
        end
    end

    // No second read reaches the slots while the result is on the bus
    assign o_read_n_masked = ready_r ? XFER_NONE : i_read_n;

    assign o_data  = data_r;
    assign o_ready = ready_r || (i_write_n != XFER_NONE);  // Writes complete at once

endmodule

// File: rtl/word_scratch_peri.sv
/*
 * Word scratch peripheral
 * One 32-bit register with byte, halfword and word writes,
 * ready one cycle after the read request
 */
`timescale 1ns/1ns

module word_scratch_peri (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [5:0]             i_addr_ofs,
    input  periph_pkg::word_t      i_data,
    input  periph_pkg::xfer_size_t i_write_n,
    input  periph_pkg::xfer_size_t i_read_n,
    output periph_pkg::word_t      o_rdata,
    output logic                   o_ready,
    output periph_pkg::byte_t      o_uo_out
);
    import periph_pkg::*;

    word_t scratch;
    logic  ready_r;
    logic  hit;

    assign hit = i_addr_ofs == 6'h00;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scratch <= '0;
            ready_r <= 1'b0;
        end else begin
            ready_r <= i_read_n != XFER_NONE;   // One cycle of read latency
            if (hit) begin
                case (i_write_n)
                    XFER_BYTE: scratch[7:0]  <= i_data[7:0];
                    XFER_HALF: scratch[15:0] <= i_data[15:0];
                    XFER_WORD: scratch       <= i_data;
                    default:   scratch       <= scratch;
                endcase
            end
        end
    end

    assign o_rdata  = hit ? scratch : '0;
    assign o_ready  = ready_r;
    assign o_uo_out = scratch[7:0];

endmodule

// File: sim/periph_bus_tb.sv
/*
 * Peripheral bus testbench
 * Drives the core-side bus of periph_bus_top, keeps a shadow model of
 * the GPIO, scratch registers and pin routing, and checks reads and pins
 */
`timescale 1ns/1ns
`include "periph_settings.svh"

module periph_bus_tb;
    import periph_pkg::*;

    localparam int GPIO_ROUNDS    = 6;
    localparam int SCRATCH_ROUNDS = 8;
    localparam int BYTE_ROUNDS    = 6;
    // Select reads, input read, GPIO, scratch, byte selects, byte bank, empty slots
    localparam int NUM_OPS = 8 + 1 + 2 * GPIO_ROUNDS + 2 * SCRATCH_ROUNDS + 2
                           + 2 * BYTE_ROUNDS + 5 + 4;
    localparam int TIMEOUT_CYCLES = 40 * (NUM_OPS + 1);   // Extra slot for reset

    logic       clk;
    logic       rst_n;
    byte_t      ui_in;
    addr_t      addr;
    word_t      data;
    xfer_size_t write_n;
    xfer_size_t read_n;
    logic       read_complete;
    word_t      o_data;
    logic       o_ready;
    byte_t      o_uo_out;
    int         cycles = 0;

    // Shadow state of the peripherals
    byte_t      gpio_out_m;
    func_sel_t  func_m [8];
    word_t      scratch_m;
    byte_t      bytes_m [4];
    byte_t      ui_m;

    periph_bus_top dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (ui_in),
        .i_addr          (addr),
        .i_data          (data),
        .i_write_n       (write_n),
        .i_read_n        (read_n),
        .i_read_complete (read_complete),
        .o_data          (o_data),
        .o_ready         (o_ready),
        .o_uo_out        (o_uo_out)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time %0t %s: got %h, expected %h", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1, "Stopping at the first error");
        end
    endtask

    function automatic addr_t word_addr(input int slot, input int ofs);
        return addr_t'((slot << 6) | ofs);
    endfunction

    function automatic addr_t byte_addr(input int slot, input int ofs);
        return addr_t'(32'h400 | (slot << 4) | ofs);
    endfunction

    function automatic void model_write(input addr_t a, input word_t d, input xfer_size_t sz);
        slot_idx_t  slot;
        logic [5:0] ofs;
        ofs = a[5:0];
        if (a[10]) begin
            slot = a[7:4];
            if (slot == slot_idx_t'(`PERI_SLOT_BYTES) && a[3:2] == 2'b00)
                bytes_m[a[1:0]] = d[7:0];       // Byte slots take any size
        end else begin
            slot = a[9:6];
            if (slot == slot_idx_t'(`PERI_SLOT_GPIO)) begin
                if (ofs == `GPIO_OFS_OUT)
                    gpio_out_m = d[7:0];
                else if (ofs >= `GPIO_OFS_FUNC_BASE && ofs[1:0] == 2'b00)
                    func_m[ofs[4:2]] = d[4:0];
            end else if (slot == slot_idx_t'(`PERI_SLOT_SCRATCH) && ofs == 6'h00) begin
                case (sz)
                    XFER_BYTE: scratch_m[7:0]  = d[7:0];
                    XFER_HALF: scratch_m[15:0] = d[15:0];
                    XFER_WORD: scratch_m       = d;
                    default:   scratch_m       = scratch_m;
                endcase
            end
        end
    endfunction

    // Reference model of the read data for any address
    function automatic word_t expected_read(input addr_t a);
        slot_idx_t  slot;
        logic [5:0] ofs;
        word_t      r;
        r   = '0;
        ofs = a[5:0];
        if (a[10]) begin
            slot = a[7:4];
            if (slot == slot_idx_t'(`PERI_SLOT_BYTES) && a[3:2] == 2'b00)
                r = {24'h0, bytes_m[a[1:0]]};
        end else begin
            slot = a[9:6];
            if (slot == slot_idx_t'(`PERI_SLOT_GPIO)) begin
                if (ofs == `GPIO_OFS_OUT)
                    r = {24'h0, gpio_out_m};
                else if (ofs == `GPIO_OFS_IN)
                    r = {24'h0, ui_m};
                else if (ofs >= `GPIO_OFS_FUNC_BASE && ofs[1:0] == 2'b00)
                    r = {27'h0, func_m[ofs[4:2]]};
            end else if (slot == slot_idx_t'(`PERI_SLOT_SCRATCH) && ofs == 6'h00) begin
                r = scratch_m;
            end
        end
        return r;
    endfunction

    function automatic byte_t source_byte(input func_sel_t sel);
        if (sel[4])
            return (sel[3:0] == slot_idx_t'(`PERI_SLOT_BYTES)) ? bytes_m[0] : 8'h00;
        if (sel[3:0] == slot_idx_t'(`PERI_SLOT_GPIO))
            return gpio_out_m;
        if (sel[3:0] == slot_idx_t'(`PERI_SLOT_SCRATCH))
            return scratch_m[7:0];
        return 8'h00;                           // Empty slots drive zero
    endfunction

    function automatic byte_t expected_pins();
        byte_t pins;
        byte_t src;
        for (int p = 0; p < 8; p++) begin
            src     = source_byte(func_m[p]);
            pins[p] = src[p];
        end
        return pins;
    endfunction

    // Pins are compared against the model on every falling edge
    always @(negedge clk) begin
        if (rst_n)
            check_value("o_uo_out", 32'(o_uo_out), 32'(expected_pins()));
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the bus did not finish its operations in time");
            $display("Testbench failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    task automatic bus_write(input addr_t a, input word_t d, input xfer_size_t sz);
        @(posedge clk);
        addr    <= a;
        data    <= d;
        write_n <= sz;
        @(negedge clk);
        check_value("o_ready on write", 32'(o_ready), 32'd1);
        @(posedge clk);
        write_n <= XFER_NONE;
        model_write(a, d, sz);                  // Registers take the write on this edge
    endtask

    task automatic read_and_check(input addr_t a);
        word_t got;
        int    lat;
        int    exp_lat;
        exp_lat = (!a[10] && a[9:6] == slot_idx_t'(`PERI_SLOT_SCRATCH)) ? 2 : 1;
        lat     = 0;
        @(posedge clk);
        addr   <= a;
        read_n <= XFER_WORD;
        do begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end while (!o_ready);
        got = o_data;
        check_value("read latency", lat, exp_lat);
        check_value("o_data", got, expected_read(a));
        @(posedge clk);
        ui_in <= ~ui_in;                        // Input pins move while the result waits
        @(negedge clk);
        ui_m = ui_in;
        check_value("o_data held", o_data, got);
        @(posedge clk);
        read_complete <= 1'b1;
        read_n        <= XFER_NONE;
        @(posedge clk);
        read_complete <= 1'b0;
    endtask

    initial begin
        xfer_size_t sz;
        addr_t      a;
        void'($urandom(32'hb463_881c));
        ui_in         <= 8'h00;
        addr          <= '0;
        data          <= '0;
        write_n       <= XFER_NONE;
        read_n        <= XFER_NONE;
        read_complete <= 1'b0;
        rst_n         <= 1'b0;
        ui_m       = 8'h00;
        gpio_out_m = 8'h00;
        scratch_m  = '0;
        for (int p = 0; p < 8; p++) begin
            func_m[p] = (p < 2) ? func_sel_t'(`PERI_SLOT_SCRATCH) : func_sel_t'(`PERI_SLOT_GPIO);
        end
        for (int r = 0; r < 4; r++) begin
            bytes_m[r] = 8'h00;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // Reset state and an idle bus
        repeat (3) begin
            @(negedge clk);
            check_value("o_ready idle", 32'(o_ready), 32'd0);
        end
        check_value("o_uo_out after reset", 32'(o_uo_out), 32'd0);
        for (int p = 0; p < 8; p++) begin
            read_and_check(word_addr(`PERI_SLOT_GPIO, `GPIO_OFS_FUNC_BASE + 4 * p));
        end

        // GPIO output register and input pins
        @(posedge clk);
        ui_in <= byte_t'($urandom());
        @(negedge clk);
        ui_m = ui_in;
        read_and_check(word_addr(`PERI_SLOT_GPIO, `GPIO_OFS_IN));
        for (int i = 0; i < GPIO_ROUNDS; i++) begin
            bus_write(word_addr(`PERI_SLOT_GPIO, `GPIO_OFS_OUT), $urandom(), XFER_WORD);
            read_and_check(word_addr(`PERI_SLOT_GPIO, `GPIO_OFS_OUT));
        end

        // Sized writes to the word scratch register
        for (int i = 0; i < SCRATCH_ROUNDS; i++) begin
            case ($urandom_range(2, 0))
                0:       sz = XFER_BYTE;
                1:       sz = XFER_HALF;
                default: sz = XFER_WORD;
            endcase
            bus_write(word_addr(`PERI_SLOT_SCRATCH, 0), $urandom(), sz);
            read_and_check(word_addr(`PERI_SLOT_SCRATCH, 0));
        end

        // Pins 4 and 5 follow byte scratch register 0
        bus_write(word_addr(`PERI_SLOT_GPIO, `GPIO_OFS_FUNC_BASE + 16), 32'h10, XFER_WORD);
        bus_write(word_addr(`PERI_SLOT_GPIO, `GPIO_OFS_FUNC_BASE + 20), 32'h10, XFER_WORD);
        for (int i = 0; i < BYTE_ROUNDS; i++) begin
            a = byte_addr(`PERI_SLOT_BYTES, i % 4);
            bus_write(a, $urandom(), XFER_BYTE);
            read_and_check(a);
        end
        for (int r = 0; r < 5; r++) begin
            read_and_check(byte_addr(`PERI_SLOT_BYTES, r));    // Offset 4 reads zero
        end

        // Unpopulated slots on the bus and on the pins
        read_and_check(word_addr(5, 0));
        read_and_check(byte_addr(3, 0));
        bus_write(word_addr(`PERI_SLOT_GPIO, `GPIO_OFS_FUNC_BASE + 24), 32'h07, XFER_WORD);
        bus_write(word_addr(`PERI_SLOT_GPIO, `GPIO_OFS_FUNC_BASE + 28), 32'h19, XFER_WORD);
        repeat (2) @(posedge clk);

        $display("Testbench passed");
        $finish;
    end

endmodule
